// ==== include/eth_rx_consts.svh ====
// Ethernet receive constants shared by the RTL and the testbench through `include
`ifndef ETH_RX_CONSTS_SVH
`define ETH_RX_CONSTS_SVH

// ------------------------------
// GMII framing
// ------------------------------
`define ETH_PREAMBLE_BYTE 8'h55             // Repeated before SFD
`define ETH_SFD_BYTE      8'hD5             // Start of frame delimiter
`define ETH_MIN_FRAME_LEN 64                // Bytes including FCS
`define ETH_FCS_LEN       4                 // CRC-32 trailer bytes
`define ETH_CRC_RESIDUE   32'hDEBB20E3      // Raw register after a good FCS

// ------------------------------
// MAC control frames
// ------------------------------
`define MCF_DST_MCAST  48'h0180C2000001
`define MCF_ETH_TYPE   16'h8808
`define MCF_OPCODE_LFC 16'h0001
`define QUANTA_CYCLES  64                   // 512 bit times at 8 bits per cycle

`endif

// ==== src/eth_rx_pkg.sv ====
// Types shared by the receive MAC blocks, referenced as eth_rx_pkg::name
package eth_rx_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    typedef logic [7:0]  byte_t;            // One GMII byte
    typedef logic [31:0] crc_t;             // Running CRC-32
    typedef logic [15:0] quanta_t;          // Pause time in quanta
    typedef logic [15:0] frame_len_t;       // Byte position in a frame

    // Framer states
    typedef enum logic [1:0] {
        IDLE,                               // Waiting for rx_dv
        PREAMBLE,                           // Skipping 55 bytes up to SFD
        PAYLOAD,                            // Frame bytes flowing
        DROP                                // Bad start, wait for rx_dv low
    } rx_state_t;

endpackage

// ==== src/rx_stream_if.sv ====
// Byte stream from the framer to its consumers inside eth_mac_rx
`timescale 1ns/1ps

interface rx_stream_if;

    eth_rx_pkg::byte_t tdata;               // One byte per valid beat
    logic              tvalid;
    logic              tlast;               // Final payload byte
    logic              tuser;               // Bad frame, only with tlast

    // No ready, the sink takes every beat
    modport src (
        output tdata, tvalid, tlast, tuser
    );

    modport mon (
        input tdata, tvalid, tlast, tuser
    );

endinterface

// ==== src/gmii_rx_framer.sv ====
// GMII receive framer instantiated by eth_mac_rx to strip and check incoming frames
`include "eth_rx_consts.svh"
`timescale 1ns/1ps

module gmii_rx_framer (
    input  logic              rx_clk,
    input  logic              rx_rst,
    input  eth_rx_pkg::byte_t gmii_rxd,
    input  logic              gmii_rx_dv,
    input  logic              gmii_rx_er,
    rx_stream_if.src          rx_out,
    output logic              start_packet,
    output logic              error_bad_frame,
    output logic              error_bad_fcs
);

    localparam eth_rx_pkg::crc_t CRC_POLY = 32'hEDB88320;  // Reflected 802.3 polynomial

    eth_rx_pkg::rx_state_t  state;
    eth_rx_pkg::frame_len_t len;                // Bytes since SFD
    eth_rx_pkg::crc_t       crc;
    eth_rx_pkg::byte_t      dly [`ETH_FCS_LEN]; // Holds back the FCS
    eth_rx_pkg::byte_t      hold_byte;          // Waits to learn if it is last
    logic                   hold_valid;
    logic                   er_seen;
    logic                   bad_fcs;
    logic                   bad_frame;

    // LSB-first byte update
    function automatic eth_rx_pkg::crc_t crc_next(
        eth_rx_pkg::crc_t  crc_in,
        eth_rx_pkg::byte_t data
    );
        eth_rx_pkg::crc_t c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            c = (c >> 1) ^ ((c[0] ^ data[i]) ? CRC_POLY : '0);
        end
        return c;
    endfunction

    assign bad_fcs   = (crc != `ETH_CRC_RESIDUE);
    assign bad_frame = er_seen || (len < `ETH_MIN_FRAME_LEN);

    // ------------------------------
    // Control and status
    // ------------------------------
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state           <= eth_rx_pkg::IDLE;
            len             <= '0;
            er_seen         <= 1'b0;
            hold_valid      <= 1'b0;
            rx_out.tvalid   <= 1'b0;
            rx_out.tlast    <= 1'b0;
            rx_out.tuser    <= 1'b0;
            start_packet    <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            rx_out.tvalid   <= 1'b0;            // Pulses by default
            rx_out.tlast    <= 1'b0;
            rx_out.tuser    <= 1'b0;
            start_packet    <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
            case (state)
                eth_rx_pkg::IDLE: begin
                    if (gmii_rx_dv) begin
                        state <= (gmii_rxd == `ETH_PREAMBLE_BYTE) ?
                                 eth_rx_pkg::PREAMBLE : eth_rx_pkg::DROP;
                    end
                end
                eth_rx_pkg::PREAMBLE: begin
                    if (!gmii_rx_dv) begin
                        state <= eth_rx_pkg::IDLE;
                    end else if (gmii_rxd == `ETH_SFD_BYTE) begin
                        state        <= eth_rx_pkg::PAYLOAD;
                        start_packet <= 1'b1;
                        len          <= '0;
                        er_seen      <= 1'b0;
                        hold_valid   <= 1'b0;
                    end else if (gmii_rxd != `ETH_PREAMBLE_BYTE) begin
                        state <= eth_rx_pkg::DROP;
                    end
                end
                eth_rx_pkg::PAYLOAD: begin
                    if (gmii_rx_dv) begin
                        if (len != '1) len <= len + 1'b1;    // Saturate on jumbo
                        if (gmii_rx_er) er_seen <= 1'b1;
                        if (len >= `ETH_FCS_LEN) hold_valid <= 1'b1;
                        rx_out.tvalid <= hold_valid;         // Previous held byte
                    end else begin
                        state <= eth_rx_pkg::IDLE;
                        if (hold_valid) begin                // Frames under 5 bytes vanish
                            rx_out.tvalid   <= 1'b1;
                            rx_out.tlast    <= 1'b1;
                            rx_out.tuser    <= bad_fcs || bad_frame;
                            error_bad_fcs   <= bad_fcs;
                            error_bad_frame <= bad_frame;
                        end
                    end
                end
                default: begin
                    if (!gmii_rx_dv) state <= eth_rx_pkg::IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------
    always_ff @(posedge rx_clk) begin
        if (state == eth_rx_pkg::PREAMBLE) crc <= '1;
        if (state == eth_rx_pkg::PAYLOAD && gmii_rx_dv) begin
            crc       <= crc_next(crc, gmii_rxd);
            hold_byte <= dly[`ETH_FCS_LEN-1];
            dly[0]    <= gmii_rxd;
            for (int i = 1; i < `ETH_FCS_LEN; i++) begin
                dly[i] <= dly[i-1];
            end
        end
        if (state == eth_rx_pkg::PAYLOAD && hold_valid) rx_out.tdata <= hold_byte;
    end

    a_last_has_valid: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_out.tlast |-> rx_out.tvalid);

    // Errors only on the closing beat
    a_error_on_last: assert property (@(posedge rx_clk) disable iff (rx_rst)
        (error_bad_fcs || error_bad_frame) |-> (rx_out.tlast && rx_out.tuser));

endmodule

// ==== src/mac_ctrl_rx_parser.sv ====
// MAC control frame detector in eth_mac_rx that watches the received stream for PAUSE
`include "eth_rx_consts.svh"
`timescale 1ns/1ps

module mac_ctrl_rx_parser (
    input  logic                rx_clk,
    input  logic                rx_rst,
    rx_stream_if.mon            rx_in,
    output logic                mcf_valid,
    output eth_rx_pkg::quanta_t mcf_quanta,
    output logic                stat_rx_mcf
);

    localparam logic [47:0] DST_MCAST   = `MCF_DST_MCAST;
    localparam logic [15:0] ETH_TYPE    = `MCF_ETH_TYPE;
    localparam logic [15:0] OPCODE_LFC  = `MCF_OPCODE_LFC;
    localparam int          QUANTA_HI   = 16;   // Beat of the quanta MSB
    localparam int          QUANTA_LO   = 17;

    eth_rx_pkg::frame_len_t pos;                // Beat index in frame
    eth_rx_pkg::byte_t      exp_byte;
    logic                   check;
    logic                   match;              // Header still matches

    // ------------------------------
    // Expected header bytes
    // ------------------------------
    always_comb begin
        check    = 1'b1;
        exp_byte = '0;
        case (pos)
            16'd0:   exp_byte = DST_MCAST[47:40];
            16'd1:   exp_byte = DST_MCAST[39:32];
            16'd2:   exp_byte = DST_MCAST[31:24];
            16'd3:   exp_byte = DST_MCAST[23:16];
            16'd4:   exp_byte = DST_MCAST[15:8];
            16'd5:   exp_byte = DST_MCAST[7:0];
            16'd12:  exp_byte = ETH_TYPE[15:8];
            16'd13:  exp_byte = ETH_TYPE[7:0];
            16'd14:  exp_byte = OPCODE_LFC[15:8];
            16'd15:  exp_byte = OPCODE_LFC[7:0];
            default: check = 1'b0;              // Source MAC and payload
        endcase
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            pos       <= '0;
            match     <= 1'b1;
            mcf_valid <= 1'b0;
        end else begin
            mcf_valid <= 1'b0;
            if (rx_in.tvalid) begin
                if (check && rx_in.tdata != exp_byte) match <= 1'b0;
                if (rx_in.tlast) begin
                    // Quanta must have arrived by the closing beat
                    mcf_valid <= !rx_in.tuser && match && (pos >= QUANTA_LO);
                    pos       <= '0;
                    match     <= 1'b1;
                end else if (pos != '1) begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

    // Quanta is big endian on the wire
    always_ff @(posedge rx_clk) begin
        if (rx_in.tvalid && pos == QUANTA_HI) mcf_quanta[15:8] <= rx_in.tdata;
        if (rx_in.tvalid && pos == QUANTA_LO) mcf_quanta[7:0] <= rx_in.tdata;
    end

    assign stat_rx_mcf = mcf_valid;

    a_mcf_single: assert property (@(posedge rx_clk) disable iff (rx_rst)
        mcf_valid |=> !mcf_valid);

endmodule

// ==== src/lfc_pause_timer.sv ====
// Link pause timer in eth_mac_rx that holds rx_lfc_req for the received pause quanta
`include "eth_rx_consts.svh"
`timescale 1ns/1ps

module lfc_pause_timer (
    input  logic                rx_clk,
    input  logic                rx_rst,
    input  logic                mcf_valid,
    input  eth_rx_pkg::quanta_t mcf_quanta,
    input  logic                rx_lfc_en,
    output logic                rx_lfc_req
);

    localparam int                CYC_W    = $clog2(`QUANTA_CYCLES);
    localparam logic [CYC_W-1:0]  CYC_LAST = CYC_W'(`QUANTA_CYCLES - 1);

    eth_rx_pkg::quanta_t quanta_cnt;            // Quanta left
    logic [CYC_W-1:0]    cyc_cnt;               // Cycles left in this quantum

    // ------------------------------
    // Countdown
    // ------------------------------
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            quanta_cnt <= '0;
            cyc_cnt    <= '0;
        end else if (!rx_lfc_en) begin
            quanta_cnt <= '0;                   // Pause abandoned
        end else if (mcf_valid) begin
            quanta_cnt <= mcf_quanta;           // Zero means resume now
            cyc_cnt    <= CYC_LAST;
        end else if (quanta_cnt != '0) begin
            if (cyc_cnt == '0) begin
                quanta_cnt <= quanta_cnt - 1'b1;
                cyc_cnt    <= CYC_LAST;
            end else begin
                cyc_cnt <= cyc_cnt - 1'b1;
            end
        end
    end

    assign rx_lfc_req = (quanta_cnt != '0);

    // Enable low must end the request by the next cycle
    a_req_needs_en: assert property (@(posedge rx_clk) disable iff (rx_rst)
        !rx_lfc_en |=> !rx_lfc_req);

endmodule

// ==== src/eth_mac_rx.sv ====
// Top level of the 1G Ethernet receive MAC with GMII in and a byte stream out
`timescale 1ns/1ps

module eth_mac_rx (
    input  logic              rx_clk,
    input  logic              rx_rst,
    // GMII
    input  eth_rx_pkg::byte_t gmii_rxd,
    input  logic              gmii_rx_dv,
    input  logic              gmii_rx_er,
    // Flow control
    input  logic              rx_lfc_en,
    output logic              rx_lfc_req,
    // Received stream
    output eth_rx_pkg::byte_t rx_tdata,
    output logic              rx_tvalid,
    output logic              rx_tlast,
    output logic              rx_tuser,
    // Status
    output logic              rx_start_packet,
    output logic              rx_error_bad_frame,
    output logic              rx_error_bad_fcs,
    output logic              stat_rx_mcf
);

    logic                mcf_valid;
    eth_rx_pkg::quanta_t mcf_quanta;

    rx_stream_if rx_stream ();

    gmii_rx_framer i_gmii_rx_framer (
        .rx_clk          (rx_clk),
        .rx_rst          (rx_rst),
        .gmii_rxd        (gmii_rxd),
        .gmii_rx_dv      (gmii_rx_dv),
        .gmii_rx_er      (gmii_rx_er),
        .rx_out          (rx_stream.src),
        .start_packet    (rx_start_packet),
        .error_bad_frame (rx_error_bad_frame),
        .error_bad_fcs   (rx_error_bad_fcs)
    );

    mac_ctrl_rx_parser i_mac_ctrl_rx_parser (
        .rx_clk      (rx_clk),
        .rx_rst      (rx_rst),
        .rx_in       (rx_stream.mon),
        .mcf_valid   (mcf_valid),
        .mcf_quanta  (mcf_quanta),
        .stat_rx_mcf (stat_rx_mcf)
    );

    lfc_pause_timer i_lfc_pause_timer (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .mcf_valid  (mcf_valid),
        .mcf_quanta (mcf_quanta),
        .rx_lfc_en  (rx_lfc_en),
        .rx_lfc_req (rx_lfc_req)
    );

    // Every frame leaves, control frames included
    assign rx_tdata  = rx_stream.tdata;
    assign rx_tvalid = rx_stream.tvalid;
    assign rx_tlast  = rx_stream.tlast;
    assign rx_tuser  = rx_stream.tuser;

endmodule

// ==== verification/rx_checker.sv ====
// Testbench monitor that compares the receive MAC outputs with queued frame expectations
`include "eth_rx_consts.svh"
`timescale 1ns/1ps

module rx_checker (
    input logic              rx_clk,
    input logic              rx_rst,
    input eth_rx_pkg::byte_t rx_tdata,
    input logic              rx_tvalid,
    input logic              rx_tlast,
    input logic              rx_tuser,
    input logic              rx_start_packet,
    input logic              rx_error_bad_frame,
    input logic              rx_error_bad_fcs,
    input logic              stat_rx_mcf,
    input logic              rx_lfc_req,
    input logic              rx_lfc_en
);

    int                error_count = 0;
    int                pass_count  = 0;
    int                fail_count  = 0;
    int                exp_id [$];
    int                exp_len [$];
    bit                exp_fcs [$];
    bit                exp_frame [$];
    bit                exp_mcf [$];
    int                exp_quanta [$];
    eth_rx_pkg::byte_t exp_data [$];
    int                beats       = 0;
    int                starts      = 0;
    int                test_errors = 0;
    bit                mcf_due     = 0;     // Frame closed so stat_rx_mcf is checked next
    bit                due_mcf;
    int                due_id;
    int                due_quanta  = 0;
    int                pause_left  = 0;     // Cycles of request still owed

    task automatic expect_frame(input int id, input int len, input bit fcs_bad,
                                input bit frame_bad, input bit mcf, input int quanta);
        exp_id.push_back(id);
        exp_len.push_back(len);
        exp_fcs.push_back(fcs_bad);
        exp_frame.push_back(frame_bad);
        exp_mcf.push_back(mcf);
        exp_quanta.push_back(quanta);
    endtask

    task automatic expect_byte(input eth_rx_pkg::byte_t b);
        exp_data.push_back(b);
    endtask

    function automatic bit busy();
        return (exp_id.size() != 0) || mcf_due;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        error_count++;
        test_errors++;
    endtask

    task automatic report_text(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    // ------------------------------
    // Sampled mid-cycle
    // ------------------------------
    always @(negedge rx_clk) begin
        if (!rx_rst) begin
            if (rx_lfc_req !== (pause_left != 0))
                report_value("rx_lfc_req", pause_left != 0, rx_lfc_req);

            if (mcf_due) begin                  // One cycle after the last beat
                if (stat_rx_mcf !== due_mcf) report_value("stat_rx_mcf", due_mcf, stat_rx_mcf);
                if (test_errors == 0) begin
                    $display("Test %0d: passed", due_id);
                    pass_count++;
                end else begin
                    $display("Test %0d: failed with %0d errors", due_id, test_errors);
                    fail_count++;
                end
                test_errors = 0;
                mcf_due     = 0;
            end else if (stat_rx_mcf) begin
                report_text("stat_rx_mcf pulsed without a frame ending the cycle before");
            end

            // Pause request model
            if (!rx_lfc_en) pause_left = 0;
            else if (stat_rx_mcf) pause_left = due_quanta * `QUANTA_CYCLES;
            else if (pause_left > 0) pause_left--;

            if (rx_start_packet) starts++;

            if (rx_tvalid) begin
                if (exp_id.size() == 0) begin
                    report_text("output byte arrived while no frame was expected");
                end else begin
                    if (exp_data.size() == 0) report_text("more output bytes than the frame holds");
                    else begin
                        eth_rx_pkg::byte_t b;
                        b = exp_data.pop_front();
                        if (rx_tdata !== b) report_value("rx_tdata", b, rx_tdata);
                    end
                    beats++;
                    if (rx_tlast) begin
                        if (beats != exp_len[0]) report_value("beat count", exp_len[0], beats);
                        if (starts != 1) report_value("rx_start_packet count", 1, starts);
                        if (rx_tuser !== (exp_fcs[0] || exp_frame[0]))
                            report_value("rx_tuser", exp_fcs[0] || exp_frame[0], rx_tuser);
                        if (rx_error_bad_fcs !== exp_fcs[0])
                            report_value("rx_error_bad_fcs", exp_fcs[0], rx_error_bad_fcs);
                        if (rx_error_bad_frame !== exp_frame[0])
                            report_value("rx_error_bad_frame", exp_frame[0], rx_error_bad_frame);
                        due_id     = exp_id.pop_front();
                        due_mcf    = exp_mcf.pop_front();
                        due_quanta = exp_quanta.pop_front();
                        void'(exp_len.pop_front());
                        void'(exp_fcs.pop_front());
                        void'(exp_frame.pop_front());
                        exp_data.delete();
                        mcf_due = 1;
                        beats   = 0;
                        starts  = 0;
                    end
                end
            end
            if (rx_tlast && !rx_tvalid) report_text("rx_tlast rose without rx_tvalid");
            if (!(rx_tvalid && rx_tlast) &&
                (rx_tuser || rx_error_bad_fcs || rx_error_bad_frame))
                report_text("rx_tuser or error status pulsed outside a last beat");
        end
    end

endmodule

// ==== verification/tb_eth_mac_rx.sv ====
// Testbench for eth_mac_rx that replays frames from the pattern file through GMII
`include "eth_rx_consts.svh"
`timescale 1ns/1ps

module tb_eth_mac_rx;

    localparam int PERIOD    = 40;
    localparam int MAX_TESTS = 32;

    logic              rx_clk;
    logic              rx_rst;
    eth_rx_pkg::byte_t gmii_rxd;
    logic              gmii_rx_dv;
    logic              gmii_rx_er;
    logic              rx_lfc_en;
    logic              rx_lfc_req;
    eth_rx_pkg::byte_t rx_tdata;
    logic              rx_tvalid;
    logic              rx_tlast;
    logic              rx_tuser;
    logic              rx_start_packet;
    logic              rx_error_bad_frame;
    logic              rx_error_bad_fcs;
    logic              stat_rx_mcf;

    int          seed     = 32'h920;
    longint      limit_ns = 0;              // Watchdog armed once nonzero
    int          n_tests  = 0;
    int          t_id [MAX_TESTS];
    int          t_len [MAX_TESTS];
    logic [47:0] t_dst [MAX_TESTS];
    logic [15:0] t_type [MAX_TESTS];
    logic [15:0] t_op [MAX_TESTS];
    logic [15:0] t_quanta [MAX_TESTS];
    int          t_corrupt [MAX_TESTS];
    int          t_er [MAX_TESTS];
    int          t_en [MAX_TESTS];
    int          t_bad [MAX_TESTS];
    int          t_mcf [MAX_TESTS];

    eth_mac_rx i_eth_mac_rx (.*);

    rx_checker rx_check (.*);

    initial begin
        rx_clk = 1'b0;
        forever #(PERIOD / 2) rx_clk = ~rx_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic read_patterns();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verification/rx_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/rx_patterns.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 4 && line.getc(0) != "#") begin  // Skip comments
                    n = $sscanf(line, "%d %d %h %h %h %h %d %d %d %d %d",
                                t_id[n_tests], t_len[n_tests], t_dst[n_tests],
                                t_type[n_tests], t_op[n_tests], t_quanta[n_tests],
                                t_corrupt[n_tests], t_er[n_tests], t_en[n_tests],
                                t_bad[n_tests], t_mcf[n_tests]);
                    if (n == 11) n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // IEEE 802.3 reflected CRC-32 giving the value sent as FCS
    function automatic logic [31:0] fcs_of(input eth_rx_pkg::byte_t data [$]);
        logic [31:0] r;
        r = 32'hFFFFFFFF;
        foreach (data[i]) begin
            r = r ^ {24'h0, data[i]};
            repeat (8) r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
        end
        return ~r;
    endfunction

    task automatic send_byte(input eth_rx_pkg::byte_t b, input logic er);
        gmii_rxd   = b;
        gmii_rx_er = er;
        @(posedge rx_clk);
        #1;
    endtask

    task automatic drive_frame(input int k);
        eth_rx_pkg::byte_t frame [$];
        logic [31:0]       fcs;
        logic [7:0]        hdr [18];
        bit                frame_bad;
        for (int i = 0; i < 6; i++) hdr[i] = t_dst[k][47 - 8*i -: 8];
        for (int i = 6; i < 12; i++) hdr[i] = (i == 11) ? t_id[k][7:0] : 8'h02;
        hdr[12] = t_type[k][15:8];
        hdr[13] = t_type[k][7:0];
        hdr[14] = t_op[k][15:8];
        hdr[15] = t_op[k][7:0];
        hdr[16] = t_quanta[k][15:8];
        hdr[17] = t_quanta[k][7:0];
        for (int i = 0; i < t_len[k]; i++)
            frame.push_back(i < 18 ? hdr[i] : 8'(i * 7 + t_id[k]));   // Fill pattern

        frame_bad = (t_er[k] != 0) || (t_len[k] + `ETH_FCS_LEN < `ETH_MIN_FRAME_LEN);
        if (t_bad[k] != ((t_corrupt[k] != 0) || frame_bad))
            rx_check.report_text($sformatf("test %0d expected bad flag %0d disagrees %s",
                                           t_id[k], t_bad[k], "with its corruption flags"));
        rx_check.expect_frame(t_id[k], t_len[k], t_corrupt[k] != 0, frame_bad,
                              t_mcf[k] != 0, t_quanta[k]);
        foreach (frame[i]) rx_check.expect_byte(frame[i]);

        fcs = fcs_of(frame);
        if (t_corrupt[k] != 0) fcs[7:0] = ~fcs[7:0];
        for (int i = 0; i < 4; i++) frame.push_back(fcs[8*i +: 8]);  // LSB first on wire

        rx_lfc_en  = t_en[k][0];
        gmii_rx_dv = 1'b1;
        repeat (7) send_byte(`ETH_PREAMBLE_BYTE, 1'b0);
        send_byte(`ETH_SFD_BYTE, 1'b0);
        foreach (frame[i]) send_byte(frame[i], (t_er[k] != 0) && (i == 20));
        gmii_rx_dv = 1'b0;
        gmii_rxd   = '0;
        gmii_rx_er = 1'b0;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        longint cycles;
        int     max_q;
        rx_rst     = 1'b1;
        gmii_rxd   = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        rx_lfc_en  = 1'b0;
        read_patterns();

        cycles = 10;
        max_q  = 0;
        for (int k = 0; k < n_tests; k++) begin
            cycles += t_len[k] + `ETH_FCS_LEN + 8 + 20 + 2;
            if (t_quanta[k] > max_q) max_q = t_quanta[k];
        end
        cycles += max_q * `QUANTA_CYCLES;
        limit_ns = cycles * 2 * PERIOD;

        repeat (3) @(posedge rx_clk);
        #1;
        rx_rst = 1'b0;
        repeat (4) @(posedge rx_clk);
        #1;

        for (int k = 0; k < n_tests; k++) begin
            drive_frame(k);
            repeat (12 + ($unsigned($random(seed)) % 9)) @(posedge rx_clk);  // 12 to 20 idle
            #1;
        end
        while (rx_check.busy() || rx_lfc_req) @(posedge rx_clk);
        repeat (4) @(posedge rx_clk);

        $display("Tests passed %0d, failed %0d, errors %0d",
                 rx_check.pass_count, rx_check.fail_count, rx_check.error_count);
        if (n_tests == 0) $display("No test patterns were read");
        if (n_tests > 0 && rx_check.error_count == 0 && rx_check.pass_count == n_tests) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
src/eth_rx_pkg.sv
src/rx_stream_if.sv
src/gmii_rx_framer.sv
src/mac_ctrl_rx_parser.sv
src/lfc_pause_timer.sv
src/eth_mac_rx.sv
verification/rx_checker.sv
verification/tb_eth_mac_rx.sv

// ==== Bender.yml ====
package:
  name: eth_mac_rx

sources:
  - include_dirs:
      - include
    files:
      - src/eth_rx_pkg.sv
      - src/rx_stream_if.sv
      - src/gmii_rx_framer.sv
      - src/mac_ctrl_rx_parser.sv
      - src/lfc_pause_timer.sv
      - src/eth_mac_rx.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/rx_checker.sv
      - verification/tb_eth_mac_rx.sv

// ==== verification/rx_patterns.txt ====
# id len dst type opcode quanta corrupt_fcs rx_er lfc_en exp_bad exp_mcf
# len is the byte count before FCS; bytes past 18 are a fill pattern
1  60 020000000001 0800 0000 0000 0 0 1 0 0
2  60 020000000001 0800 0000 0000 1 0 1 1 0
3  40 020000000001 0800 0000 0000 0 0 1 1 0
4  60 020000000001 0800 0000 0000 0 1 1 1 0
5  60 0180c2000001 8808 0001 0003 0 0 1 0 1
6  60 0180c2000001 8808 0001 0000 0 0 1 0 1
7  60 0180c2000001 8808 0001 0002 0 0 1 0 1
8  60 0180c2000001 8808 0002 0004 0 0 1 0 0
9  60 0180c2000001 8808 0001 0004 1 0 1 1 0
10 60 0180c2000001 8808 0001 0002 0 0 0 0 1
11 72 0180c2000001 8808 0001 0001 0 0 1 0 1
